// ==== cacc_calc_macros.svh ====
`ifndef CACC_CALC_MACROS_SVH
`define CACC_CALC_MACROS_SVH

// ====================
// Int8 datapath widths
// ====================
`define CACC_IN_W   22  // Product sum from the MAC array
`define CACC_OP_W   34  // Stored operand and partial sum
`define CACC_SUM_W  35  // Raw adder result, one guard bit
`define CACC_OUT_W  32  // Final result to the delivery side

// ====================
// Truncate and rounding
// ====================
`define CACC_FRAC_W 16  // Fraction bits appended before shift
`define CACC_TRU_W  5   // Truncate amount field

// Derived shift word width, integer plus fraction
`define CACC_SFT_W  (`CACC_OP_W + `CACC_FRAC_W)

`endif

// ==== cacc_ctrl_pkg.sv ====
`include "cacc_calc_macros.svh"

// ====================
// Control side types
// ====================
package cacc_ctrl_pkg;

  // Right shift applied to final sums, from the register file
  typedef logic [`CACC_TRU_W-1:0] cacc_truncate_t;

  // Qualifiers that travel with the final result
  typedef struct packed {
    logic valid;  // Final result strobe
    logic sat;    // Final result clipped to 32 bits
  } cacc_final_flag_t;

endpackage

// ==== cacc_data_pkg.sv ====
`include "cacc_calc_macros.svh"

// ====================
// Datapath word types
// ====================
package cacc_data_pkg;

  typedef logic signed [`CACC_IN_W-1:0]  cacc_in_t;   // Signed product sum
  typedef logic signed [`CACC_OP_W-1:0]  cacc_op_t;   // Operand or partial sum
  typedef logic signed [`CACC_OUT_W-1:0] cacc_out_t;  // Final result word

  // Sum stage to round stage, the 34-bit saturated value
  // is {sign, mag}
  typedef struct packed {
    logic                   final_vld;  // Valid and last of accumulation
    logic                   sign;       // Sign of the raw 35-bit sum
    logic [`CACC_OP_W-2:0]  mag;        // Low bits after clipping
  } cacc_sat_word_t;

  // Shifted word split at the binary point
  typedef struct packed {
    logic [`CACC_OP_W-1:0]    integ;   // Integer part after shift
    logic                     guide;   // First bit below the point
    logic [`CACC_FRAC_W-2:0]  sticky;  // Remaining fraction bits
  } cacc_shift_fields_t;

  // Same 50 bits seen as the shifter output or as split fields
  typedef union packed {
    logic [`CACC_SFT_W-1:0] raw;  // Arithmetic shifter result
    cacc_shift_fields_t     f;    // Rounding view
  } cacc_shift_word_u;

endpackage

// ==== cacc_sum_stage.sv ====
`timescale 1ns/100ps

`include "cacc_calc_macros.svh"

module cacc_sum_stage
  import cacc_data_pkg::*;
(
  input  logic           nvdla_core_clk,
  input  logic           nvdla_core_rstn,
  input  logic           i_valid,          // Item strobe
  input  logic           i_sel,            // Last item of accumulation
  input  cacc_in_t       i_data,           // Product sum
  input  cacc_op_t       i_op,             // Stored operand
  input  logic           i_op_valid,       // Operand present, else zero
  output cacc_sat_word_t o_sat,            // To round stage
  output logic           o_partial_valid,
  output cacc_op_t       o_partial_data
);

  cacc_op_t                op_mask;     // Operand after valid masking
  logic [`CACC_SUM_W-1:0]  sum_nxt;     // Adder output
  logic [`CACC_SUM_W-1:0]  sum_pd;      // Registered raw sum
  logic                    sat_vld;     // Item in sum register
  logic                    sat_sel;     // Held select of that item
  logic                    sum_sign;
  logic                    sum_msb;
  logic [`CACC_OP_W-2:0]   sat_mag;     // Clipped low bits
  logic                    partial_vld;
  logic                    final_vld;

  // ====================
  // Addition
  // ====================
  assign op_mask = i_op_valid ? i_op : '0;  // Missing operand adds nothing

  // Both sides sign extended to 35 bits
  assign sum_nxt = {{(`CACC_SUM_W-`CACC_IN_W){i_data[`CACC_IN_W-1]}}, i_data} +
                   {{(`CACC_SUM_W-`CACC_OP_W){op_mask[`CACC_OP_W-1]}}, op_mask};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      sat_vld <= 1'b0;
      sat_sel <= 1'b0;
    end else begin
      sat_vld <= i_valid;
      if (i_valid) begin
        sat_sel <= i_sel;  // Hold select with its data
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (i_valid) begin
      sum_pd <= sum_nxt;
    end
  end

  // ====================
  // Clip to 34 bits
  // ====================
  assign sum_sign = sum_pd[`CACC_SUM_W-1];
  assign sum_msb  = sum_pd[`CACC_SUM_W-2];

  // Top bits disagree on overflow, clip toward the sign
  assign sat_mag = (sum_sign ^ sum_msb) ? {(`CACC_OP_W-1){~sum_sign}}
                                        : sum_pd[`CACC_OP_W-2:0];

  assign partial_vld = sat_vld & ~sat_sel;  // Mid accumulation
  assign final_vld   = sat_vld & sat_sel;   // Last item, goes to rounding

  assign o_sat = '{final_vld: final_vld, sign: sum_sign, mag: sat_mag};

  // ====================
  // Partial output
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      o_partial_valid <= 1'b0;
    end else begin
      o_partial_valid <= partial_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (partial_vld) begin
      o_partial_data <= {sum_sign, sat_mag};  // Back to the accumulator buffer
    end
  end

endmodule

// ==== cacc_round_stage.sv ====
`timescale 1ns/100ps

`include "cacc_calc_macros.svh"

module cacc_round_stage
  import cacc_ctrl_pkg::*, cacc_data_pkg::*;
(
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  cacc_sat_word_t   i_sat,           // Saturated sum from sum stage
  input  cacc_truncate_t   i_cfg_truncate,  // Quasi static shift amount
  output cacc_final_flag_t o_final,         // Final valid and sat flag
  output cacc_out_t        o_final_data
);

  cacc_op_t                 pre_sft;       // Shifter input, zero when idle
  cacc_shift_word_u         sft_w;         // Shifted word, two views
  logic                     sat_sign;
  logic                     point5;        // Round up increment
  logic                     need_sat;      // Result does not fit 32 bits
  logic [`CACC_OUT_W-1:0]   tru_pd;        // Rounded low 32 bits
  cacc_out_t                sft_max;       // Signed 32-bit extreme
  cacc_out_t                final_result;
  cacc_final_flag_t         final_nxt;

  assign sat_sign = i_sat.sign;

  // ====================
  // Truncate shift
  // ====================
  // Only a final item toggles the shifter
  assign pre_sft = i_sat.final_vld ? {i_sat.sign, i_sat.mag} : '0;

  // Fraction appended so shifted out bits feed rounding
  always_comb begin
    sft_w.raw = $signed({pre_sft, {`CACC_FRAC_W{1'b0}}}) >>> i_cfg_truncate;
  end

  // ====================
  // Rounding
  // ====================
  // Half rounds away from zero, negatives need sticky to go up
  assign point5 = sft_w.f.guide & (~sat_sign | (|sft_w.f.sticky));

  assign tru_pd = sft_w.f.integ[`CACC_OUT_W-1:0] + {{(`CACC_OUT_W-1){1'b0}}, point5};

  // ====================
  // Clip to 32 bits
  // ====================
  // Negative overflow, bits 32:31 not all ones
  // Positive overflow, either of bits 32:31 set
  // Positive, all ones below bit 31 and a round up carry
  assign need_sat = (sat_sign & ~(&sft_w.f.integ[`CACC_OUT_W:`CACC_OUT_W-1])) |
                    (~sat_sign & (|sft_w.f.integ[`CACC_OUT_W:`CACC_OUT_W-1])) |
                    (~sat_sign & (&{sft_w.f.integ[`CACC_OUT_W-2:0], point5}));

  assign sft_max = sat_sign ? {1'b1, {(`CACC_OUT_W-1){1'b0}}}   // Most negative
                            : {1'b0, {(`CACC_OUT_W-1){1'b1}}};  // Most positive

  assign final_result = need_sat ? sft_max : tru_pd;

  assign final_nxt = '{valid: i_sat.final_vld, sat: i_sat.final_vld & need_sat};

  // ====================
  // Final output
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      o_final <= '0;
    end else begin
      o_final <= final_nxt;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (i_sat.final_vld) begin
      o_final_data <= final_result;  // Held between final items
    end
  end

endmodule

// ==== cacc_calc_int8.sv ====
`timescale 1ns/100ps

module cacc_calc_int8
  import cacc_ctrl_pkg::*, cacc_data_pkg::*;
(
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  cacc_truncate_t   i_cfg_truncate,   // Register file shift amount
  input  logic             i_valid,          // Item strobe
  input  cacc_in_t         i_data,           // Product sum from MAC
  input  cacc_op_t         i_op,             // Operand from the buffer
  input  logic             i_op_valid,
  input  logic             i_sel,            // Last item
  output logic             o_partial_valid,
  output cacc_op_t         o_partial_data,   // Back to accumulator buffer
  output cacc_final_flag_t o_final,          // Final valid and sat hit
  output cacc_out_t        o_final_data      // To delivery
);

  cacc_sat_word_t sat_word;  // Saturated 34-bit sum with final qualifier

  // ====================
  // Add and clip
  // ====================
  cacc_sum_stage u_sum (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_valid         (i_valid),
    .i_sel           (i_sel),
    .i_data          (i_data),
    .i_op            (i_op),
    .i_op_valid      (i_op_valid),
    .o_sat           (sat_word),
    .o_partial_valid (o_partial_valid),
    .o_partial_data  (o_partial_data)
  );

  // ====================
  // Shift and round
  // ====================
  cacc_round_stage u_round (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_sat           (sat_word),
    .i_cfg_truncate  (i_cfg_truncate),
    .o_final         (o_final),
    .o_final_data    (o_final_data)
  );

endmodule

// ==== cacc_calc_int8_chk.sv ====
`timescale 1ns/100ps

module cacc_calc_int8_chk
  import cacc_ctrl_pkg::*;
(
  input logic             nvdla_core_clk,
  input logic             nvdla_core_rstn,
  input logic             i_partial_valid,  // Partial strobe of the top level
  input cacc_final_flag_t i_final           // Final strobe and sat hit
);

  int n_fail = 0;  // Assertion failures so far

  // ====================
  // Output strobes
  // ====================
  a_one_strobe: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      !(i_partial_valid && i_final.valid))
    else begin
      n_fail++;
      $error("Partial and final valid high in the same cycle");
    end

  a_sat_qual: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      i_final.sat |-> i_final.valid)  // Flag only rides a final result
    else begin
      n_fail++;
      $error("Saturation flag high without final valid");
    end

  a_reset_quiet: assert property (@(posedge nvdla_core_clk)
      !nvdla_core_rstn |-> !i_partial_valid && !i_final.valid && !i_final.sat)
    else begin
      n_fail++;
      $error("Output strobe high during reset");
    end

endmodule

bind cacc_calc_int8 cacc_calc_int8_chk u_chk (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .i_partial_valid (o_partial_valid),
  .i_final         (o_final)
);

// ==== tb_cacc_calc_int8.sv ====
`timescale 1ns/100ps

`include "cacc_calc_macros.svh"

module tb_cacc_calc_int8
  import cacc_ctrl_pkg::*, cacc_data_pkg::*;
();

  localparam int     RST_CYCLES = 8;
  localparam int     NUM_BLOCKS = 48;   // Truncate changes once per block
  localparam int     BLOCK_LEN  = 24;
  localparam int     WAIT_LIMIT = 64;
  localparam longint IN_MAX  = (64'sd1 <<< (`CACC_IN_W-1)) - 1;
  localparam longint IN_MIN  = -(64'sd1 <<< (`CACC_IN_W-1));
  localparam longint OP_MAX  = (64'sd1 <<< (`CACC_OP_W-1)) - 1;
  localparam longint OP_MIN  = -(64'sd1 <<< (`CACC_OP_W-1));
  localparam longint OUT_MAX = (64'sd1 <<< (`CACC_OUT_W-1)) - 1;
  localparam longint OUT_MIN = -(64'sd1 <<< (`CACC_OUT_W-1));

  typedef struct packed {
    logic             pvld;   // Partial strobe expected
    cacc_op_t         pdata;
    cacc_final_flag_t flag;   // Final strobe and sat hit
    cacc_out_t        fdata;
  } expect_t;

  logic             nvdla_core_clk;
  logic             nvdla_core_rstn;
  cacc_truncate_t   i_cfg_truncate;
  logic             i_valid;
  cacc_in_t         i_data;
  cacc_op_t         i_op;
  logic             i_op_valid;
  logic             i_sel;
  logic             o_partial_valid;
  cacc_op_t         o_partial_data;
  cacc_final_flag_t o_final;
  cacc_out_t        o_final_data;

  expect_t     expq[$];     // One entry per cycle, idle ones too
  logic [31:0] lcg_state;
  int          err_partial;
  int          err_final;
  int          err_flag;
  int          err_valid;
  int          err_other;   // Timeouts and missed stimulus corners
  int          n_psat;
  int          n_fsat;
  int          n_fnorm;

  cacc_calc_int8 DUT (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;  // 20 ns period
  end

  // ====================
  // Stimulus and model
  // ====================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic longint clip_op(longint s);
    if (s > OP_MAX) return OP_MAX;
    if (s < OP_MIN) return OP_MIN;
    return s;
  endfunction

  function automatic expect_t model_item(logic vld, logic last, cacc_in_t d, cacc_op_t o,
                                         logic ov, cacc_truncate_t tru);
    expect_t e;
    longint  v;
    longint  w;
    longint  integ;
    longint  rsum;
    logic    rnd;
    e = '0;
    v = clip_op(longint'(d) + (ov ? longint'(o) : 64'sd0));  // Missing operand is zero
    w = (v <<< `CACC_FRAC_W) >>> tru;                          // Fixed point shift
    integ = w >>> `CACC_FRAC_W;
    rnd = w[`CACC_FRAC_W-1] && ((v >= 0) || (w[`CACC_FRAC_W-2:0] != 0));
    rsum = integ + (rnd ? 1 : 0);
    if (vld && !last) begin
      e.pvld  = 1'b1;
      e.pdata = cacc_op_t'(v);
    end
    if (vld && last) begin
      e.flag.valid = 1'b1;
      e.flag.sat   = (v < 0) ? (integ < OUT_MIN) : (rsum > OUT_MAX);  // Negatives before round
      e.fdata      = e.flag.sat ? cacc_out_t'((v < 0) ? OUT_MIN : OUT_MAX) : cacc_out_t'(rsum);
    end
    return e;
  endfunction

  task automatic drive_item(logic vld, logic last, cacc_in_t d, cacc_op_t o, logic ov);
    i_valid    = vld;
    i_sel      = last;
    i_data     = d;
    i_op       = o;
    i_op_valid = ov;
    expq.push_back(model_item(vld, last, d, o, ov, i_cfg_truncate));
  endtask

  task automatic random_item();
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rb;
    cacc_in_t    d;
    cacc_op_t    o;
    r  = next_random();
    ra = next_random();
    rb = next_random();
    if (r[31:29] == 3'd0) begin
      d = r[28] ? cacc_in_t'(IN_MAX) : cacc_in_t'(IN_MIN);  // Extreme product sum
    end else begin
      d = ra[31:10];
    end
    case (r[27:25])
      3'd0:       o = cacc_op_t'(OP_MAX);
      3'd1:       o = cacc_op_t'(OP_MIN);
      3'd2:       o = cacc_op_t'(OP_MAX - rb[23:8]);  // Near the top
      3'd3:       o = cacc_op_t'(OP_MIN + rb[23:8]);
      3'd4, 3'd5: o = {{12{rb[31]}}, rb[31:10]};      // Small operand
      default:    o = {rb, ra[9:8]};
    endcase
    drive_item(r[24:22] != 3'd0, r[20], d, o, r[19:18] != 2'd0);
  endtask

  // ====================
  // Compare tasks
  // ====================
  task automatic check_valid(string name, logic exp_v, logic act_v);
    if (act_v !== exp_v) begin
      err_valid++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_partial(string name, cacc_op_t exp_v, cacc_op_t act_v);
    if (act_v !== exp_v) begin
      err_partial++;
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_final(string name, cacc_out_t exp_v, cacc_out_t act_v);
    if (act_v !== exp_v) begin
      err_final++;
      $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_flags(string name, cacc_final_flag_t exp_v, cacc_final_flag_t act_v);
    if (act_v !== exp_v) begin
      err_flag++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    e = expq.pop_front();
    check_valid("o_partial_valid", e.pvld, o_partial_valid);
    check_flags("o_final", e.flag, o_final);
    if (e.pvld) check_partial("o_partial_data", e.pdata, o_partial_data);
    if (e.flag.valid) check_final("o_final_data", e.fdata, o_final_data);
    if (e.pvld && (e.pdata == cacc_op_t'(OP_MAX) || e.pdata == cacc_op_t'(OP_MIN))) n_psat++;
    if (e.flag.valid && e.flag.sat) n_fsat++;
    if (e.flag.valid && !e.flag.sat) n_fnorm++;
  endtask

  // Results of the item two cycles back are stable at this edge
  task automatic step_cycle();
    @(negedge nvdla_core_clk);
    if (expq.size() >= 2) check_outputs();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int          blk;
    int          k;
    int          n;
    int          n_assert;
    logic [31:0] r;
    lcg_state       = 32'hf943;
    err_partial     = 0;
    err_final       = 0;
    err_flag        = 0;
    err_valid       = 0;
    err_other       = 0;
    n_psat          = 0;
    n_fsat          = 0;
    n_fnorm         = 0;
    nvdla_core_rstn = 1'b0;
    i_cfg_truncate  = '0;
    i_valid         = 1'b0;
    i_data          = '0;
    i_op            = '0;
    i_op_valid      = 1'b0;
    i_sel           = 1'b0;
    for (k = 0; k < RST_CYCLES; k++) begin
      @(negedge nvdla_core_clk);
      check_valid("o_partial_valid", 1'b0, o_partial_valid);  // Quiet under reset
      check_flags("o_final", '0, o_final);
    end
    nvdla_core_rstn = 1'b1;
    drive_item(1'b0, 1'b0, '0, '0, 1'b0);  // Idle inputs of the last two reset cycles
    drive_item(1'b0, 1'b0, '0, '0, 1'b0);
    for (blk = 0; blk < NUM_BLOCKS; blk++) begin
      step_cycle();
      drive_item(1'b0, 1'b0, '0, '0, 1'b0);
      step_cycle();
      r = next_random();
      i_cfg_truncate = (r[26:25] == 2'd0) ? '0 : r[31:27];  // Nothing in flight here
      drive_item(1'b0, 1'b0, '0, '0, 1'b0);
      for (k = 0; k < BLOCK_LEN; k++) begin
        step_cycle();
        random_item();
      end
    end
    @(negedge nvdla_core_clk);
    check_outputs();
    i_valid = 1'b0;
    n = 0;
    while (expq.size() > 0 && n < WAIT_LIMIT) begin  // Drain the last item
      @(negedge nvdla_core_clk);
      check_outputs();
      n++;
    end
    if (expq.size() > 0) begin
      err_other++;
      $display("Timed out draining the expected results");
    end
    if (n_psat == 0 || n_fsat == 0 || n_fnorm == 0) begin
      err_other++;
      $display("Stimulus missed a saturation or a plain final case");
    end
    n_assert = DUT.u_chk.n_fail;
    $display("Errors: partial %0d, final %0d, flags %0d, valid %0d, other %0d, assert %0d",
             err_partial, err_final, err_flag, err_valid, err_other, n_assert);
    if (err_partial + err_final + err_flag + err_valid + err_other + n_assert == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
cacc_ctrl_pkg.sv
cacc_data_pkg.sv
cacc_sum_stage.sv
cacc_round_stage.sv
cacc_calc_int8.sv
cacc_calc_int8_chk.sv
tb_cacc_calc_int8.sv

// ==== Bender.yml ====
package:
  name: cacc_calc_int8

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cacc_ctrl_pkg.sv
      - cacc_data_pkg.sv
      - cacc_sum_stage.sv
      - cacc_round_stage.sv
      - cacc_calc_int8.sv
  - target: test
    include_dirs:
      - .
    files:
      - cacc_calc_int8_chk.sv
      - tb_cacc_calc_int8.sv
